/* Bender.yml */
package:
  name: deco

sources:
  - files:
      - common/deco_pkg.sv
      - rtl/pipe_reg.sv
      - decoder/ea_decode.sv
      - decoder/opcode_table.sv
      - decoder/deco_top.sv

  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/deco_tb.sv

/* common/deco_pkg.sv */
// decoder package with widths, register codes, microcode entry points and record types
package deco_pkg;

        localparam int seq_addr_w = 8;  // microcode entry point width

        typedef enum logic [seq_addr_w-1:0] {
                logrrb, logrrw, logrmb, logrmw, logmrb, logmrw,
                logirb, logirw, logimb, logimw,
                movrrb, movrrw, movrmb, movrmw, movmrb, movmrw,
                movirb, movirw,
                incrb, incmb, decrb, decmb,
                incrw, incmw, decrw, decmw,
                pushr, pushm, popr, jcc,
                callnr, callnm, callfm,
                jmpr, jmpm, ljmpm,
                nop,
                invop
        } seq_addr_t;

        // general registers in x86 order, then the segment registers
        typedef enum logic [3:0] {
                reg_ax,
                reg_cx,
                reg_dx,
                reg_bx,
                reg_sp,
                reg_bp,
                reg_si,
                reg_di,
                reg_es,
                reg_cs,
                reg_ss,
                reg_ds,
                reg_none                // no register
        } reg_code_t;

        typedef enum logic [1:0] {
                seg_es,
                seg_cs,
                seg_ss,
                seg_ds
        } seg_t;

        typedef struct packed {
                logic en;               // override prefix seen
                seg_t seg;
        } seg_ovr_t;

        typedef struct packed {
                logic [7:0] op;
                logic [7:0] modrm;
                seg_ovr_t   sovr;
        } instr_t;

        typedef struct packed {
                reg_code_t base;
                reg_code_t index;
                seg_t      seg;
                logic      disp_needed;
                logic      disp_wide;   // 16 bit displacement
        } ea_t;

        typedef struct packed {
                seq_addr_t seq_addr;
                logic      need_modrm;
                logic      need_off;
                logic      need_imm;
                logic      off_size;
                logic      imm_size;
                reg_code_t src;
                reg_code_t dst;
                ea_t       ea;
        } deco_t;

endpackage

/* decoder/deco_top.sv */
// two-stage pipelined opcode decoder with valid/ready handshake on both sides
`timescale 1ns/1ps

module deco_top (
        input  logic             clk,
        input  logic             arst_n,

        input  logic             in_valid,
        output logic             in_ready,
        input  deco_pkg::instr_t instr,

        output logic             out_valid,
        input  logic             out_ready,
        output deco_pkg::deco_t  deco
);

        deco_pkg::instr_t instr_q;      // registered instruction
        logic             instr_valid;
        logic             instr_ready;
        deco_pkg::ea_t    ea;
        deco_pkg::deco_t  deco_d;

        pipe_reg #(
                .payload_t (deco_pkg::instr_t)
        ) stage_in (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_data   (instr),
                .out_valid (instr_valid),
                .out_ready (instr_ready),
                .out_data  (instr_q)
        );

        ea_decode ea0 (
                .modrm (instr_q.modrm),
                .sovr  (instr_q.sovr),
                .ea    (ea)
        );

        opcode_table table0 (
                .instr (instr_q),
                .ea    (ea),
                .deco  (deco_d)
        );

        pipe_reg #(
                .payload_t (deco_pkg::deco_t)
        ) stage_out (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (instr_valid),
                .in_ready  (instr_ready),
                .in_data   (deco_d),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_data  (deco)
        );

endmodule

/* decoder/ea_decode.sv */
// effective-address decode of the ModR/M byte with segment override
`timescale 1ns/1ps

module ea_decode (
        input  logic [7:0]         modrm,
        input  deco_pkg::seg_ovr_t sovr,
        output deco_pkg::ea_t      ea
);

        logic [1:0] mod;
        logic [2:0] rm;
        logic       direct;     // disp16 only, no registers

        assign mod = modrm[7:6];
        assign rm = modrm[2:0];
        assign direct = (mod == 2'b00) && (rm == 3'd6);

        always_comb
        begin
                ea.index = deco_pkg::reg_none;
                case (rm)
                3'd0:
                begin
                        ea.base = deco_pkg::reg_bx;
                        ea.index = deco_pkg::reg_si;
                end
                3'd1:
                begin
                        ea.base = deco_pkg::reg_bx;
                        ea.index = deco_pkg::reg_di;
                end
                3'd2:
                begin
                        ea.base = deco_pkg::reg_bp;
                        ea.index = deco_pkg::reg_si;
                end
                3'd3:
                begin
                        ea.base = deco_pkg::reg_bp;
                        ea.index = deco_pkg::reg_di;
                end
                3'd4: ea.base = deco_pkg::reg_si;
                3'd5: ea.base = deco_pkg::reg_di;
                3'd6: ea.base = direct ? deco_pkg::reg_none : deco_pkg::reg_bp;
                default: ea.base = deco_pkg::reg_bx;
                endcase

                if (sovr.en)
                        ea.seg = sovr.seg;
                else if (ea.base == deco_pkg::reg_bp)
                        ea.seg = deco_pkg::seg_ss;      // stack relative
                else
                        ea.seg = deco_pkg::seg_ds;

                ea.disp_needed = direct | (mod == 2'b01) | (mod == 2'b10);
                ea.disp_wide = direct | (mod == 2'b10);
        end

endmodule

/* decoder/opcode_table.sv */
// opcode lookup giving microcode entry point, operand registers and follow-on byte needs
`timescale 1ns/1ps

module opcode_table (
        input  deco_pkg::instr_t instr,
        input  deco_pkg::ea_t    ea,
        output deco_pkg::deco_t  deco
);

        logic                reg_form;  // mod == 11
        logic                b;         // byte operand
        logic                d;         // reg field is destination
        logic [2:0]          regf;
        logic [2:0]          rmf;
        deco_pkg::reg_code_t reg_r;
        deco_pkg::reg_code_t rm_r;
        deco_pkg::reg_code_t low_r;     // register in opcode bits

        assign reg_form = (instr.modrm[7:6] == 2'b11);
        assign b = ~instr.op[0];
        assign d = instr.op[1];
        assign regf = instr.modrm[5:3];
        assign rmf = instr.modrm[2:0];
        assign reg_r = deco_pkg::reg_code_t'({1'b0, regf});
        assign rm_r = deco_pkg::reg_code_t'({1'b0, rmf});
        assign low_r = deco_pkg::reg_code_t'({1'b0, instr.op[2:0]});

        always_comb
        begin
                logic modrm_form;

                modrm_form = 1'b0;
                deco = '0;
                deco.seq_addr = deco_pkg::invop;

                casez (instr.op)
                8'b00??_?0??: // alu r/m forms
                begin
                        if (reg_form)
                                deco.seq_addr = b ? deco_pkg::logrrb : deco_pkg::logrrw;
                        else if (d)
                                deco.seq_addr = b ? deco_pkg::logmrb : deco_pkg::logmrw;
                        else
                                deco.seq_addr = b ? deco_pkg::logrmb : deco_pkg::logrmw;
                        deco.dst = d ? reg_r : rm_r;
                        deco.src = d ? rm_r : reg_r;
                        modrm_form = 1'b1;
                end
                8'b00??_?10?: // alu accumulator, imm
                begin
                        deco.seq_addr = b ? deco_pkg::logirb : deco_pkg::logirw;
                        deco.need_imm = 1'b1;
                        deco.imm_size = ~b;
                end
                8'b0100_0???: // inc reg
                begin
                        deco.seq_addr = deco_pkg::incrw;
                        deco.src = low_r;
                end
                8'b0100_1???: // dec reg
                begin
                        deco.seq_addr = deco_pkg::decrw;
                        deco.src = low_r;
                end
                8'b0101_0???:
                begin
                        deco.seq_addr = deco_pkg::pushr;
                        deco.src = low_r;
                end
                8'b0101_1???:
                begin
                        deco.seq_addr = deco_pkg::popr;
                        deco.dst = low_r;
                end
                8'b0111_????: // condition code rides in src
                begin
                        deco.seq_addr = deco_pkg::jcc;
                        deco.need_imm = 1'b1;
                        deco.src = deco_pkg::reg_code_t'(instr.op[3:0]);
                end
                8'b1000_00??: // alu r/m, imm
                begin
                        if (reg_form)
                                deco.seq_addr = b ? deco_pkg::logirb : deco_pkg::logirw;
                        else
                                deco.seq_addr = b ? deco_pkg::logimb : deco_pkg::logimw;
                        deco.need_imm = 1'b1;
                        deco.imm_size = ~instr.op[1] & instr.op[0];    // 83 is sign-extended imm8
                        deco.dst = rm_r;
                        modrm_form = 1'b1;
                end
                8'b1000_10??: // mov r/m
                begin
                        if (reg_form)
                        begin
                                deco.seq_addr = b ? deco_pkg::movrrb : deco_pkg::movrrw;
                                deco.dst = d ? reg_r : rm_r;
                                deco.src = d ? rm_r : reg_r;
                        end
                        else if (d)
                        begin
                                deco.seq_addr = b ? deco_pkg::movmrb : deco_pkg::movmrw;
                                deco.dst = reg_r;
                        end
                        else
                        begin
                                deco.seq_addr = b ? deco_pkg::movrmb : deco_pkg::movrmw;
                                deco.src = reg_r;
                        end
                        modrm_form = 1'b1;
                end
                8'b1011_????: // mov reg, imm
                begin
                        deco.seq_addr = instr.op[3] ? deco_pkg::movirw : deco_pkg::movirb;
                        deco.need_imm = 1'b1;
                        deco.imm_size = instr.op[3];
                        deco.dst = low_r;
                end
                8'b1111_1110: // byte inc/dec on r/m
                begin
                        case (regf)
                        3'd0: deco.seq_addr = reg_form ? deco_pkg::incrb : deco_pkg::incmb;
                        3'd1: deco.seq_addr = reg_form ? deco_pkg::decrb : deco_pkg::decmb;
                        default: deco.seq_addr = deco_pkg::invop;
                        endcase
                        if (deco.seq_addr != deco_pkg::invop)
                        begin
                                deco.src = rm_r;
                                modrm_form = 1'b1;
                        end
                end
                8'b1111_1111:
                begin
                        case (regf)
                        3'd0: deco.seq_addr = reg_form ? deco_pkg::incrw : deco_pkg::incmw;
                        3'd1: deco.seq_addr = reg_form ? deco_pkg::decrw : deco_pkg::decmw;
                        3'd2: deco.seq_addr = reg_form ? deco_pkg::callnr : deco_pkg::callnm;
                        3'd3: deco.seq_addr = deco_pkg::callfm;
                        3'd4: deco.seq_addr = reg_form ? deco_pkg::jmpr : deco_pkg::jmpm;
                        3'd5: deco.seq_addr = deco_pkg::ljmpm;
                        3'd6: deco.seq_addr = reg_form ? deco_pkg::pushr : deco_pkg::pushm;
                        default: deco.seq_addr = deco_pkg::invop;
                        endcase
                        if (deco.seq_addr != deco_pkg::invop)
                        begin
                                deco.src = rm_r;
                                modrm_form = 1'b1;
                        end
                end
                default:
                        deco.seq_addr = deco_pkg::invop;
                endcase

                // displacement is zero for register forms
                if (modrm_form)
                begin
                        deco.need_modrm = 1'b1;
                        deco.need_off = ea.disp_needed;
                        deco.off_size = ea.disp_wide;
                        deco.ea = ea;
                end
        end

endmodule

/* rtl/pipe_reg.sv */
// single-entry valid/ready pipeline register for an arbitrary payload type
`timescale 1ns/1ps

module pipe_reg #(
        parameter type payload_t = logic [7:0]
) (
        input  logic     clk,
        input  logic     arst_n,

        input  logic     in_valid,
        output logic     in_ready,
        input  payload_t in_data,

        output logic     out_valid,
        input  logic     out_ready,
        output payload_t out_data
);

        logic full;

        // accept when empty or draining this cycle
        assign in_ready = ~full | out_ready;
        assign out_valid = full;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        full <= 1'b0;
                else if (in_ready)
                        full <= in_valid;       // refill or empty
        end

        always_ff @(posedge clk)
        begin
                if (in_valid && in_ready)
                        out_data <= in_data;
        end

endmodule

/* verif/deco_ref.svh */
// reference model that computes the expected decode record of the opcode decoder
`ifndef DECO_REF_SVH
`define DECO_REF_SVH

function automatic deco_pkg::ea_t compute_ea(input logic [7:0] modrm,
                                             input deco_pkg::seg_ovr_t sovr);
        deco_pkg::ea_t e;
        logic [1:0]    md;
        logic [2:0]    rm;
        logic          direct;

        md = modrm[7:6];
        rm = modrm[2:0];
        direct = (md == 2'd0) && (rm == 3'd6);
        e = '0;
        if (!rm[2])
        begin
                // bit 1 picks BP over BX and bit 0 picks DI over SI
                e.base = rm[1] ? deco_pkg::reg_bp : deco_pkg::reg_bx;
                e.index = rm[0] ? deco_pkg::reg_di : deco_pkg::reg_si;
        end
        else
        begin
                e.index = deco_pkg::reg_none;
                case (rm[1:0])
                2'd0: e.base = deco_pkg::reg_si;
                2'd1: e.base = deco_pkg::reg_di;
                2'd2: e.base = direct ? deco_pkg::reg_none : deco_pkg::reg_bp;
                default: e.base = deco_pkg::reg_bx;
                endcase
        end
        if (sovr.en)
                e.seg = sovr.seg;
        else
                e.seg = (e.base == deco_pkg::reg_bp) ? deco_pkg::seg_ss : deco_pkg::seg_ds;
        e.disp_needed = direct || (md == 2'd1) || (md == 2'd2);
        e.disp_wide = direct || (md == 2'd2);
        return e;
endfunction

function automatic deco_pkg::deco_t predict_decode(input deco_pkg::instr_t x);
        deco_pkg::deco_t     r;
        logic [7:0]          op;
        logic [2:0]          rg;
        logic                regm;      // mod 11
        logic                w;         // word operand
        logic                uses_modrm;
        deco_pkg::reg_code_t rg_code;
        deco_pkg::reg_code_t rm_code;
        deco_pkg::reg_code_t low_code;

        op = x.op;
        rg = x.modrm[5:3];
        regm = (x.modrm[7:6] == 2'b11);
        w = op[0];
        rg_code = deco_pkg::reg_code_t'({1'b0, rg});
        rm_code = deco_pkg::reg_code_t'({1'b0, x.modrm[2:0]});
        low_code = deco_pkg::reg_code_t'({1'b0, op[2:0]});
        r = '0;
        r.seq_addr = deco_pkg::invop;
        uses_modrm = 1'b0;

        if ((op < 8'h40) && (op[2:1] != 2'b11) && !op[2])
        begin
                uses_modrm = 1'b1;
                if (regm)
                        r.seq_addr = w ? deco_pkg::logrrw : deco_pkg::logrrb;
                else if (op[1])
                        r.seq_addr = w ? deco_pkg::logmrw : deco_pkg::logmrb;
                else
                        r.seq_addr = w ? deco_pkg::logrmw : deco_pkg::logrmb;
                r.dst = op[1] ? rg_code : rm_code;
                r.src = op[1] ? rm_code : rg_code;
        end
        else if ((op < 8'h40) && (op[2:1] == 2'b10))
        begin
                r.seq_addr = w ? deco_pkg::logirw : deco_pkg::logirb;
                r.need_imm = 1'b1;
                r.imm_size = w;
        end
        else if (op[7:5] == 3'b010)
        begin
                case (op[4:3])
                2'd0: r.seq_addr = deco_pkg::incrw;
                2'd1: r.seq_addr = deco_pkg::decrw;
                2'd2: r.seq_addr = deco_pkg::pushr;
                default: r.seq_addr = deco_pkg::popr;
                endcase
                if (op[4:3] == 2'd3)
                        r.dst = low_code;
                else
                        r.src = low_code;
        end
        else if (op[7:4] == 4'h7)
        begin
                r.seq_addr = deco_pkg::jcc;
                r.need_imm = 1'b1;
                r.src = deco_pkg::reg_code_t'(op[3:0]);        // condition code
        end
        else if (op[7:2] == 6'b100000)
        begin
                uses_modrm = 1'b1;
                if (regm)
                        r.seq_addr = w ? deco_pkg::logirw : deco_pkg::logirb;
                else
                        r.seq_addr = w ? deco_pkg::logimw : deco_pkg::logimb;
                r.need_imm = 1'b1;
                r.imm_size = (op[1:0] == 2'b01);
                r.dst = rm_code;
        end
        else if (op[7:2] == 6'b100010)
        begin
                uses_modrm = 1'b1;
                if (regm)
                begin
                        r.seq_addr = w ? deco_pkg::movrrw : deco_pkg::movrrb;
                        r.dst = op[1] ? rg_code : rm_code;
                        r.src = op[1] ? rm_code : rg_code;
                end
                else if (op[1])
                begin
                        r.seq_addr = w ? deco_pkg::movmrw : deco_pkg::movmrb;
                        r.dst = rg_code;
                end
                else
                begin
                        r.seq_addr = w ? deco_pkg::movrmw : deco_pkg::movrmb;
                        r.src = rg_code;
                end
        end
        else if (op[7:4] == 4'hb)
        begin
                r.seq_addr = op[3] ? deco_pkg::movirw : deco_pkg::movirb;
                r.need_imm = 1'b1;
                r.imm_size = op[3];
                r.dst = low_code;
        end
        else if (op == 8'hfe)
        begin
                if (rg == 3'd0)
                        r.seq_addr = regm ? deco_pkg::incrb : deco_pkg::incmb;
                else if (rg == 3'd1)
                        r.seq_addr = regm ? deco_pkg::decrb : deco_pkg::decmb;
        end
        else if (op == 8'hff)
        begin
                case (rg)
                3'd0: r.seq_addr = regm ? deco_pkg::incrw : deco_pkg::incmw;
                3'd1: r.seq_addr = regm ? deco_pkg::decrw : deco_pkg::decmw;
                3'd2: r.seq_addr = regm ? deco_pkg::callnr : deco_pkg::callnm;
                3'd3: r.seq_addr = deco_pkg::callfm;
                3'd4: r.seq_addr = regm ? deco_pkg::jmpr : deco_pkg::jmpm;
                3'd5: r.seq_addr = deco_pkg::ljmpm;
                3'd6: r.seq_addr = regm ? deco_pkg::pushr : deco_pkg::pushm;
                default: r.seq_addr = deco_pkg::invop;
                endcase
        end

        if (op[7:1] == 7'b1111111 && r.seq_addr != deco_pkg::invop)
        begin
                uses_modrm = 1'b1;
                r.src = rm_code;
        end
        if (uses_modrm)
        begin
                r.need_modrm = 1'b1;
                r.ea = compute_ea(x.modrm, x.sovr);
                r.need_off = r.ea.disp_needed;
                r.off_size = r.ea.disp_wide;
        end
        return r;
endfunction

`endif

/* verif/deco_tb.sv */
// testbench for the pipelined opcode decoder with scoreboard and reference model
`timescale 1ns/1ps

module deco_tb;

        localparam int t_reset = 0;
        localparam int t_opcodes = 1;
        localparam int t_ea = 2;
        localparam int t_dropped = 3;
        localparam int t_latency = 4;
        localparam int t_random = 5;
        localparam int n_lat = 64;
        localparam int n_rand = 200;
        localparam int n_records = 2 * 256 + 120 + 256 + 7 + n_lat + n_rand;
        localparam int max_cycles = n_records * 4 + 50;

        logic             clk = 1'b0;
        logic             arst_n;
        logic             in_valid;
        logic             in_ready;
        deco_pkg::instr_t instr;
        logic             out_valid;
        logic             out_ready;
        deco_pkg::deco_t  deco;

        deco_pkg::deco_t  exp_q[$];     // expected results in arrival order
        int               id_q[$];
        int               acc_q[$];     // acceptance cycle
        int               cur_id;
        int               cycle = 0;
        int               checks = 0;
        int               errors = 0;
        logic             hold_pending = 1'b0;
        deco_pkg::deco_t  held;

        `include "deco_ref.svh"

        deco_top dut0 (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .instr     (instr),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .deco      (deco)
        );

        always #5 clk = ~clk;

        function automatic string test_name(input int id);
                case (id)
                t_reset: return "reset";
                t_opcodes: return "opcodes";
                t_ea: return "ea_modes";
                t_dropped: return "dropped";
                t_latency: return "latency";
                default: return "random";
                endcase
        endfunction

        function automatic deco_pkg::instr_t draw_instr();
                deco_pkg::instr_t r;
                logic [31:0]      v;

                v = $urandom;
                r.op = v[7:0];
                r.modrm = v[15:8];
                r.sovr.en = v[16];
                r.sovr.seg = deco_pkg::seg_t'(v[18:17]);
                return r;
        endfunction

        task automatic check_idle();
                checks++;
                assert (!out_valid && in_ready)
                else
                begin
                        errors++;
                        $display("ERROR reset: expected out_valid/in_ready 0/1, actual %b/%b",
                                 out_valid, in_ready);
                end
        endtask

        // called on a falling edge, returns on the falling edge after acceptance
        task automatic send_record(input deco_pkg::instr_t rec);
                instr = rec;
                in_valid = 1'b1;
                @(posedge clk);
                while (!in_ready)
                        @(posedge clk);
                @(negedge clk);
        endtask

        task automatic drain_pipeline();
                in_valid = 1'b0;
                out_ready = 1'b1;
                while (exp_q.size() != 0)
                        @(negedge clk);
        endtask

        task automatic random_traffic(input int count);
                int   sent;
                logic accepted;

                sent = 0;
                while (sent < count)
                begin
                        out_ready = ($urandom % 2) != 0;
                        if (!in_valid && ($urandom % 4 != 0))
                        begin
                                instr = draw_instr();
                                in_valid = 1'b1;
                        end
                        @(posedge clk);
                        accepted = in_valid && in_ready;
                        @(negedge clk);
                        if (accepted)
                        begin
                                in_valid = 1'b0;
                                sent++;
                        end
                end
        endtask

        // compare one output transfer with the oldest expected record
        task automatic compare_output();
                deco_pkg::deco_t exp;
                int              id;
                int              t0;

                checks++;
                assert (exp_q.size() != 0)
                else
                begin
                        errors++;
                        $display("output transfer with no record outstanding");
                end
                if (exp_q.size() != 0)
                begin
                        exp = exp_q.pop_front();
                        id = id_q.pop_front();
                        t0 = acc_q.pop_front();
                        checks++;
                        assert (deco == exp)
                        else
                        begin
                                errors++;
                                $display("ERROR %s: expected %h, actual %h",
                                         test_name(id), exp, deco);
                        end
                        if (id == t_dropped)
                        begin
                                checks++;
                                assert (deco.seq_addr == deco_pkg::invop && !deco.need_modrm &&
                                        !deco.need_off && !deco.need_imm)
                                else
                                begin
                                        errors++;
                                        $display("ERROR dropped: expected invop, actual %h",
                                                 deco);
                                end
                        end
                        if (id == t_latency)
                        begin
                                checks++;
                                assert (cycle - t0 == 2)
                                else
                                begin
                                        errors++;
                                        $display("ERROR latency: expected 2, actual %0d",
                                                 cycle - t0);
                                end
                        end
                end
        endtask

        // compare output transfers and record new acceptances
        always @(posedge clk)
        begin
                if (arst_n)
                begin
                        cycle++;
                        if (hold_pending)
                        begin
                                checks++;
                                assert (out_valid && deco == held)
                                else
                                begin
                                        errors++;
                                        $display("ERROR stall: expected %h, actual %h",
                                                 held, deco);
                                end
                        end
                        if (out_valid && out_ready)
                                compare_output();
                        if (in_valid && in_ready)
                        begin
                                exp_q.push_back(predict_decode(instr));
                                id_q.push_back(cur_id);
                                acc_q.push_back(cycle);
                        end
                        hold_pending = out_valid && !out_ready;
                        held = deco;
                end
        end

        initial
        begin
                repeat (max_cycles) @(posedge clk);
                $display("watchdog expired after %0d cycles, the run did not finish", max_cycles);
                $display("TEST FAILED");
                $finish;
        end

        initial
        begin
                deco_pkg::instr_t rec;
                deco_pkg::deco_t  model;
                int               i;
                int               k;
                int               ov;

                void'($urandom(76));
                arst_n = 1'b0;
                in_valid = 1'b0;
                out_ready = 1'b0;
                instr = '0;
                cur_id = t_reset;
                repeat (3)
                begin
                        @(negedge clk);
                        check_idle();
                end
                arst_n = 1'b1;
                @(negedge clk);
                check_idle();
                out_ready = 1'b1;

                cur_id = t_opcodes;
                for (i = 0; i < 256; i++)
                begin
                        for (k = 0; k < 2; k++)
                        begin
                                rec = draw_instr();
                                rec.op = i[7:0];
                                send_record(rec);
                        end
                end
                drain_pipeline();

                cur_id = t_ea;
                for (i = 0; i < 3; i++)
                begin
                        for (k = 0; k < 8; k++)
                        begin
                                for (ov = 0; ov < 5; ov++)
                                begin
                                        rec = draw_instr();
                                        rec.op = 8'h8b;         // mov r16, r/m16
                                        rec.modrm = {i[1:0], rec.modrm[5:3], k[2:0]};
                                        rec.sovr.en = (ov != 0);
                                        rec.sovr.seg = deco_pkg::seg_t'(ov[1:0] - 2'd1);
                                        send_record(rec);
                                end
                        end
                end
                drain_pipeline();

                cur_id = t_dropped;
                for (i = 0; i < 256; i++)
                begin
                        rec = draw_instr();
                        rec.op = i[7:0];
                        model = predict_decode(rec);
                        if (model.seq_addr == deco_pkg::invop)
                                send_record(rec);
                end
                for (k = 2; k < 9; k++)
                begin
                        rec = draw_instr();
                        rec.op = (k == 8) ? 8'hff : 8'hfe;
                        rec.modrm[5:3] = (k == 8) ? 3'd7 : k[2:0];
                        send_record(rec);
                end
                drain_pipeline();

                cur_id = t_latency;
                for (i = 0; i < n_lat; i++)
                        send_record(draw_instr());
                drain_pipeline();

                cur_id = t_random;
                random_traffic(n_rand);
                drain_pipeline();
                repeat (2) @(negedge clk);

                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

/* verilog.f */
+incdir+verif
common/deco_pkg.sv
rtl/pipe_reg.sv
decoder/ea_decode.sv
decoder/opcode_table.sv
decoder/deco_top.sv
verif/deco_tb.sv
